//--- all.f
common/soc_pkg.sv
prci/soc_prci.sv
gpio/soc_gpio.sv
logic/bus_fabric.sv
logic/soc_top.sv
sim/tb_soc_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_soc_top -f all.f
out=$(./obj_dir/Vtb_soc_top || true)
echo "$out"
echo "$out" | grep -qx "Test passed"

//--- sim/tb_soc_top.sv
// Testbench for the SoC register subsystem
// Brings the resets up from PLL lock, then drives host and debug traffic.
// Concurrent assertions compare responses with a model of OUT and DIR.

`timescale 1ns/1ns

module tb_soc_top;

  // Whole sequence takes a few hundred cycles
  localparam int TIMEOUT_CYCLES = 4000;

  logic              i_sys_clk = 1'b0;
  logic              i_rst_n;
  logic              i_pll_locked;
  logic              i_host_req;
  soc_pkg::bus_req_t i_host_cmd;
  logic              o_host_done;
  soc_pkg::bus_rsp_t o_host_rsp;
  logic              i_dbg_req;
  soc_pkg::bus_req_t i_dbg_cmd;
  logic              o_dbg_done;
  soc_pkg::bus_rsp_t o_dbg_rsp;
  soc_pkg::gpio_t    i_gpio;
  soc_pkg::gpio_t    o_gpio;
  soc_pkg::gpio_t    o_gpio_dir;
  logic              o_sys_nrst;
  logic              o_dbg_nrst;

  soc_pkg::gpio_t     model_out = '0;
  soc_pkg::gpio_t     model_dir = '0;
  soc_pkg::bus_data_t host_exp = '0;
  soc_pkg::bus_data_t dbg_exp = '0;
  logic               host_chk = 1'b0;
  logic               dbg_chk = 1'b0;
  logic               race = 1'b0;
  logic               dbg_seen = 1'b0;
  logic               host_blocked = 1'b0;
  logic [15:0]        lfsr = 16'd24;
  int                 lock_age = 0;
  int                 unlock_age = 0;
  int                 host_age = 0;
  int                 dbg_age = 0;
  int                 cycle_cnt = 0;
  int                 val_errs = 0;
  int                 oth_errs = 0;

  soc_top uut (.*);

  always #2 i_sys_clk = ~i_sys_clk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  task automatic take_bits(input int n, output soc_pkg::bus_data_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic value_err(input string name, input soc_pkg::bus_data_t exp,
                           input soc_pkg::bus_data_t got);
    val_errs++;
    $display("** Error @%0t: %s expected %h, got %h", $time, name, exp, got);
  endtask

  task automatic other_err(input string msg);
    oth_errs++;
    $display("Failure @%0t: %s", $time, msg);
  endtask

  // Raise one request pulse, reads also arm the response check
  task automatic issue(input bit dbg, input logic we, input soc_pkg::bus_addr_t a,
                       input soc_pkg::bus_data_t d, input soc_pkg::bus_data_t exp);
    if (dbg) begin
      i_dbg_cmd = '{we: we, addr: a, wdata: d};
      i_dbg_req = 1'b1;
      dbg_chk   = !we;
      dbg_exp   = exp;
    end else begin
      i_host_cmd = '{we: we, addr: a, wdata: d};
      i_host_req = 1'b1;
      host_chk   = !we;
      host_exp   = exp;
    end
  endtask

  // One more edge so the done cycle is sampled before the next issue
  task automatic wait_done(input bit dbg);
    while (!(dbg ? o_dbg_done : o_host_done)) begin
      @(negedge i_sys_clk);
    end
    @(negedge i_sys_clk);
  endtask

  task automatic access(input bit dbg, input logic we, input soc_pkg::bus_addr_t a,
                        input soc_pkg::bus_data_t d, input soc_pkg::bus_data_t exp);
    issue(dbg, we, a, d, exp);
    @(negedge i_sys_clk);
    i_host_req = 1'b0;
    i_dbg_req  = 1'b0;
    wait_done(dbg);
  endtask

  always @(posedge i_sys_clk) begin
    lock_age   <= i_pll_locked ? lock_age + 1 : 0;
    unlock_age <= i_pll_locked ? 0 : unlock_age + 1;
    host_age   <= i_host_req ? 1 : host_age + 1;
    dbg_age    <= i_dbg_req ? 1 : dbg_age + 1;
    dbg_seen   <= race && (dbg_seen || o_dbg_done);
  end

  // Scoreboard of OUT and DIR, follows the done pulses in order
  always @(negedge i_sys_clk) begin
    soc_pkg::bus_req_t done_cmd;
    if (!o_sys_nrst) begin
      model_out = '0;
      model_dir = '0;
    end else if (o_dbg_done || o_host_done) begin
      done_cmd = o_dbg_done ? i_dbg_cmd : i_host_cmd;
      if (done_cmd.we && done_cmd.addr == soc_pkg::ADDR_GPIO_OUT) begin
        model_out = done_cmd.wdata[11:0];
      end
      if (done_cmd.we && done_cmd.addr == soc_pkg::ADDR_GPIO_DIR) begin
        model_dir = done_cmd.wdata[11:0];
      end
    end
  end

  a_rst_release: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    lock_age == soc_pkg::RST_HOLD_CYCLES + 3 |-> o_sys_nrst && o_dbg_nrst)
    else other_err("resets not released in time after lock");
  a_lock_loss: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    unlock_age == 4 |-> !o_sys_nrst)
    else other_err("o_sys_nrst still high after loss of lock");
  a_dbg_hold: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    !$fell(o_dbg_nrst))
    else other_err("o_dbg_nrst dropped after power-up");
  a_dbg_rdata: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    o_dbg_done && dbg_chk |-> o_dbg_rsp.rdata == dbg_exp)
    else value_err("o_dbg_rsp.rdata", $sampled(dbg_exp), $sampled(o_dbg_rsp.rdata));
  a_host_rdata: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    o_host_done && host_chk |-> o_host_rsp.rdata == host_exp)
    else value_err("o_host_rsp.rdata", $sampled(host_exp), $sampled(o_host_rsp.rdata));
  a_gpio_out: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    o_sys_nrst |-> o_gpio == model_out)
    else value_err("o_gpio", 32'($sampled(model_out)), 32'($sampled(o_gpio)));
  a_gpio_dir: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    o_sys_nrst |-> o_gpio_dir == model_dir)
    else value_err("o_gpio_dir", 32'($sampled(model_dir)), 32'($sampled(o_gpio_dir)));
  // Debug never waits, host waits one access when it loses
  a_dbg_lat: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    o_dbg_done |-> dbg_age == 2)
    else value_err("o_dbg_done latency", 2, $sampled(dbg_age));
  a_host_lat: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    o_host_done |-> host_age == (race ? 3 : 2))
    else value_err("o_host_done latency", race ? 3 : 2, $sampled(host_age));
  a_dbg_first: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    o_host_done && race |-> dbg_seen)
    else other_err("host finished before debug in a same-cycle race");
  a_host_blocked: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    host_blocked |-> !o_host_done)
    else other_err("host request made during system reset completed");

  initial begin
    soc_pkg::bus_data_t rnd;
    soc_pkg::bus_data_t rnd2;
    i_rst_n      = 1'b0;
    i_pll_locked = 1'b0;
    i_host_req   = 1'b0;
    i_host_cmd   = '0;
    i_dbg_req    = 1'b0;
    i_dbg_cmd    = '0;
    i_gpio       = '0;
    repeat (16) @(negedge i_sys_clk);
    i_rst_n = 1'b1;
    repeat (5) @(negedge i_sys_clk);
    i_pll_locked = 1'b1;
    while (!(o_sys_nrst && o_dbg_nrst)) @(negedge i_sys_clk);
    access(1, 1'b0, soc_pkg::ADDR_PRCI_STATUS, 0, 32'd3);
    // GPIO write, readback and input sampling
    take_bits(12, rnd);
    access(0, 1'b1, soc_pkg::ADDR_GPIO_OUT, rnd, 0);
    access(1, 1'b0, soc_pkg::ADDR_GPIO_OUT, 0, rnd & 32'hFFF);
    take_bits(12, rnd);
    access(1, 1'b1, soc_pkg::ADDR_GPIO_DIR, rnd, 0);
    access(0, 1'b0, soc_pkg::ADDR_GPIO_DIR, 0, rnd & 32'hFFF);
    take_bits(12, rnd);
    i_gpio = rnd[11:0];
    repeat (3) @(negedge i_sys_clk);
    access(0, 1'b0, soc_pkg::ADDR_GPIO_IN, 0, rnd & 32'hFFF);
    // Same-cycle writes from both masters
    take_bits(12, rnd);
    take_bits(12, rnd2);
    race = 1'b1;
    issue(1, 1'b1, soc_pkg::ADDR_GPIO_OUT, rnd, 0);
    issue(0, 1'b1, soc_pkg::ADDR_GPIO_OUT, rnd2, 0);
    @(negedge i_sys_clk);
    i_host_req = 1'b0;
    i_dbg_req  = 1'b0;
    wait_done(1);
    wait_done(0);
    race = 1'b0;
    access(1, 1'b0, soc_pkg::ADDR_GPIO_OUT, 0, rnd2 & 32'hFFF);
    // Soft reset, host is locked out while debug keeps working
    access(1, 1'b1, soc_pkg::ADDR_PRCI_CTRL, 1, 0);
    host_blocked = 1'b1;
    issue(0, 1'b0, soc_pkg::ADDR_PRCI_STATUS, 0, 0);
    @(negedge i_sys_clk);
    i_host_req = 1'b0;
    access(1, 1'b0, soc_pkg::ADDR_PRCI_STATUS, 0, 32'd1);
    access(1, 1'b0, soc_pkg::ADDR_GPIO_OUT, 0, 0);
    while (!o_sys_nrst) @(negedge i_sys_clk);
    repeat (4) @(negedge i_sys_clk);
    host_blocked = 1'b0;
    // Unmapped address
    take_bits(12, rnd2);
    access(0, 1'b1, soc_pkg::ADDR_GPIO_OUT, rnd2, 0);
    access(1, 1'b0, 8'h40, 0, soc_pkg::BUS_ERR_DATA);
    take_bits(32, rnd);
    access(0, 1'b1, 8'h40, rnd, 0);
    access(0, 1'b0, soc_pkg::ADDR_GPIO_OUT, 0, rnd2 & 32'hFFF);
    // Loss of lock and recovery
    i_pll_locked = 1'b0;
    repeat (8) @(negedge i_sys_clk);
    access(1, 1'b0, soc_pkg::ADDR_PRCI_STATUS, 0, 0);
    i_pll_locked = 1'b1;
    while (!o_sys_nrst) @(negedge i_sys_clk);
    access(1, 1'b0, soc_pkg::ADDR_PRCI_STATUS, 0, 32'd3);
    access(0, 1'b0, soc_pkg::ADDR_GPIO_OUT, 0, 0);
    repeat (4) @(negedge i_sys_clk);
    $display("Errors: %0d wrong values, %0d other failures", val_errs, oth_errs);
    if (val_errs + oth_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge i_sys_clk);
      cycle_cnt++;
    end
    $display("Timeout: test sequence did not end within %0d cycles", cycle_cnt);
    $display("Errors: %0d wrong values, %0d other failures", val_errs, oth_errs);
    $display("Test failed");
    $finish;
  end

endmodule

//--- logic/soc_top.sv
// Top of the register subsystem
// Ties the reset controller, the two-master bus fabric and the GPIO block.
// Pads and the PLL live outside; GPIO direction is exported for the board.

`timescale 1ns/1ns

module soc_top (
  input  logic              i_sys_clk,
  input  logic              i_rst_n,
  input  logic              i_pll_locked,
  // Host master, in the system reset domain
  input  logic              i_host_req,
  input  soc_pkg::bus_req_t i_host_cmd,
  output logic              o_host_done,
  output soc_pkg::bus_rsp_t o_host_rsp,
  // Debug master, in the debug reset domain
  input  logic              i_dbg_req,
  input  soc_pkg::bus_req_t i_dbg_cmd,
  output logic              o_dbg_done,
  output soc_pkg::bus_rsp_t o_dbg_rsp,
  // GPIO pins
  input  soc_pkg::gpio_t    i_gpio,
  output soc_pkg::gpio_t    o_gpio,
  output soc_pkg::gpio_t    o_gpio_dir,
  // Reset outputs
  output logic              o_sys_nrst,
  output logic              o_dbg_nrst
);

  soc_pkg::bus_req_t w_bus_req;
  soc_pkg::bus_rsp_t w_prci_rsp;
  soc_pkg::bus_rsp_t w_gpio_rsp;
  logic              w_prci_sel;
  logic              w_gpio_sel;

  soc_prci prci0 (
    .i_sys_clk   (i_sys_clk),
    .i_rst_n     (i_rst_n),
    .i_pll_locked(i_pll_locked),
    .i_sel       (w_prci_sel),
    .i_req       (w_bus_req),
    .o_rsp       (w_prci_rsp),
    .o_sys_nrst  (o_sys_nrst),
    .o_dbg_nrst  (o_dbg_nrst)
  );

  bus_fabric fabric0 (
    .i_sys_clk  (i_sys_clk),
    .i_rst_n    (i_rst_n),
    .i_sys_nrst (o_sys_nrst),
    .i_dbg_nrst (o_dbg_nrst),
    .i_host_req (i_host_req),
    .i_host_cmd (i_host_cmd),
    .o_host_done(o_host_done),
    .o_host_rsp (o_host_rsp),
    .i_dbg_req  (i_dbg_req),
    .i_dbg_cmd  (i_dbg_cmd),
    .o_dbg_done (o_dbg_done),
    .o_dbg_rsp  (o_dbg_rsp),
    .i_prci_rsp (w_prci_rsp),
    .i_gpio_rsp (w_gpio_rsp),
    .o_req      (w_bus_req),
    .o_prci_sel (w_prci_sel),
    .o_gpio_sel (w_gpio_sel)
  );

  soc_gpio gpio0 (
    .i_sys_clk (i_sys_clk),
    .i_rst_n   (i_rst_n),
    .i_sys_nrst(o_sys_nrst),
    .i_sel     (w_gpio_sel),
    .i_req     (w_bus_req),
    .i_gpio    (i_gpio),
    .o_rsp     (w_gpio_rsp),
    .o_gpio    (o_gpio),
    .o_gpio_dir(o_gpio_dir)
  );

endmodule

//--- logic/bus_fabric.sv
// Register bus fabric for two masters and two slaves
// Each port holds one pending request; debug wins over host when both wait.
// The granted command goes to all slaves with a decoded select, and the
// response comes back with a registered done pulse one cycle later.

`timescale 1ns/1ns

module bus_fabric (
  input  logic              i_sys_clk,
  input  logic              i_rst_n,
  input  logic              i_sys_nrst,
  input  logic              i_dbg_nrst,
  // Host master
  input  logic              i_host_req,
  input  soc_pkg::bus_req_t i_host_cmd,
  output logic              o_host_done,
  output soc_pkg::bus_rsp_t o_host_rsp,
  // Debug master
  input  logic              i_dbg_req,
  input  soc_pkg::bus_req_t i_dbg_cmd,
  output logic              o_dbg_done,
  output soc_pkg::bus_rsp_t o_dbg_rsp,
  // Slave side
  input  soc_pkg::bus_rsp_t i_prci_rsp,
  input  soc_pkg::bus_rsp_t i_gpio_rsp,
  output soc_pkg::bus_req_t o_req,
  output logic              o_prci_sel,
  output logic              o_gpio_sel
);

  // Port index 0 is host, 1 is debug
  logic [1:0]              req;
  logic [1:0]              port_nrst;
  logic [1:0]              pend;
  logic [1:0]              grant;
  logic [1:0]              done_q;
  soc_pkg::bus_req_t [1:0] cmd_in;
  soc_pkg::bus_req_t [1:0] cmd_q;
  soc_pkg::bus_rsp_t [1:0] rsp_q;
  soc_pkg::bus_rsp_t       rsp;
  logic                    hit_prci;
  logic                    hit_gpio;

  assign req       = {i_dbg_req, i_host_req};
  assign port_nrst = {i_dbg_nrst, i_sys_nrst};
  assign cmd_in    = {i_dbg_cmd, i_host_cmd};

  // Pending flags, dropped while the port's domain is in reset
  always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pend   <= '0;
      done_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!port_nrst[i]) begin
          pend[i] <= 1'b0;
        end else if (req[i]) begin
          pend[i] <= 1'b1;
        end else if (grant[i]) begin
          pend[i] <= 1'b0;
        end
      end
      done_q <= grant;
    end
  end

  always_ff @(posedge i_sys_clk) begin
    for (int i = 0; i < 2; i++) begin
      if (req[i] && !pend[i]) begin
        cmd_q[i] <= cmd_in[i];
      end
      if (grant[i]) begin
        rsp_q[i] <= rsp;
      end
    end
  end

  // Fixed priority, debug first
  always_comb begin
    grant[1] = pend[1] && port_nrst[1];
    grant[0] = pend[0] && port_nrst[0] && !grant[1];
  end

  assign o_req = grant[1] ? cmd_q[1] : cmd_q[0];

  // Address decode
  assign hit_prci = (o_req.addr == soc_pkg::ADDR_PRCI_STATUS) ||
                    (o_req.addr == soc_pkg::ADDR_PRCI_CTRL);
  assign hit_gpio = (o_req.addr == soc_pkg::ADDR_GPIO_OUT) ||
                    (o_req.addr == soc_pkg::ADDR_GPIO_DIR) ||
                    (o_req.addr == soc_pkg::ADDR_GPIO_IN);

  assign o_prci_sel = (|grant) && hit_prci;
  assign o_gpio_sel = (|grant) && hit_gpio;

  // Unmapped writes just complete with no select raised
  always_comb begin
    if (hit_prci) begin
      rsp = i_prci_rsp;
    end else if (hit_gpio) begin
      rsp = i_gpio_rsp;
    end else begin
      rsp.rdata = soc_pkg::BUS_ERR_DATA;
    end
  end

  assign o_host_done = done_q[0];
  assign o_dbg_done  = done_q[1];
  assign o_host_rsp  = rsp_q[0];
  assign o_dbg_rsp   = rsp_q[1];

  // A master waits for its done pulse before the next request
  for (genvar g = 0; g < 2; g++) begin : g_port_chk
    a_no_overrun: assert property (
      @(posedge i_sys_clk) disable iff (!i_rst_n)
        (req[g] && port_nrst[g]) |-> !pend[g])
      else $error("request on port %0d while one is still pending", g);
  end

  a_one_sel: assert property (
    @(posedge i_sys_clk) disable iff (!i_rst_n)
      $onehot0({o_prci_sel, o_gpio_sel}))
    else $error("more than one slave selected");

endmodule

//--- gpio/soc_gpio.sv
// GPIO register slave for 12 pins
// OUT and DIR drive the pads; IN samples the pins through two flops.
// Both registers clear on the power-on reset and on the system reset.

`timescale 1ns/1ns

module soc_gpio (
  input  logic              i_sys_clk,
  input  logic              i_rst_n,
  input  logic              i_sys_nrst,
  input  logic              i_sel,
  input  soc_pkg::bus_req_t i_req,
  input  soc_pkg::gpio_t    i_gpio,
  output soc_pkg::bus_rsp_t o_rsp,
  output soc_pkg::gpio_t    o_gpio,
  output soc_pkg::gpio_t    o_gpio_dir
);

  soc_pkg::gpio_t out_q;
  soc_pkg::gpio_t dir_q;
  soc_pkg::gpio_t in_meta;
  soc_pkg::gpio_t in_sync;
  logic           wr_en;

  assign wr_en = i_sel && i_req.we;

  always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      out_q <= '0;
      dir_q <= '0;
    end else if (!i_sys_nrst) begin
      out_q <= '0;
      dir_q <= '0;
    end else if (wr_en) begin
      if (i_req.addr == soc_pkg::ADDR_GPIO_OUT) begin
        out_q <= soc_pkg::gpio_t'(i_req.wdata);
      end
      if (i_req.addr == soc_pkg::ADDR_GPIO_DIR) begin
        dir_q <= soc_pkg::gpio_t'(i_req.wdata);
      end
    end
  end

  // Pins are asynchronous to the bus clock
  always_ff @(posedge i_sys_clk) begin
    in_meta <= i_gpio;
    in_sync <= in_meta;
  end

  assign o_gpio     = out_q;
  assign o_gpio_dir = dir_q;

  always_comb begin
    case (i_req.addr)
      soc_pkg::ADDR_GPIO_OUT: o_rsp.rdata = soc_pkg::bus_data_t'(out_q);
      soc_pkg::ADDR_GPIO_DIR: o_rsp.rdata = soc_pkg::bus_data_t'(dir_q);
      soc_pkg::ADDR_GPIO_IN:  o_rsp.rdata = soc_pkg::bus_data_t'(in_sync);
      default:                o_rsp.rdata = '0;
    endcase
  end

endmodule

//--- prci/soc_prci.sv
// Power, reset and clock interface block
// Synchronizes the PLL lock and sequences the system and debug resets.
// The debug reset is released once after power-up; the system reset also
// follows loss of lock and soft reset writes to the CTRL register.

`timescale 1ns/1ns

module soc_prci (
  input  logic              i_sys_clk,
  input  logic              i_rst_n,
  input  logic              i_pll_locked,
  input  logic              i_sel,
  input  soc_pkg::bus_req_t i_req,
  output soc_pkg::bus_rsp_t o_rsp,
  output logic              o_sys_nrst,
  output logic              o_dbg_nrst
);

  typedef enum logic [1:0] {
    WAIT_LOCK,
    HOLD,
    RUN
  } state_t;

  state_t             state;
  soc_pkg::hold_cnt_t hold_cnt;
  logic               lock_meta;
  logic               lock_sync;
  logic               sys_nrst_q;
  logic               dbg_nrst_q;
  logic               soft_rst;

  // Lock comes straight from the PLL, two flops before use
  always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      lock_meta <= 1'b0;
      lock_sync <= 1'b0;
    end else begin
      lock_meta <= i_pll_locked;
      lock_sync <= lock_meta;
    end
  end

  // Soft reset request from a CTRL write
  assign soft_rst = i_sel && i_req.we && (i_req.addr == soc_pkg::ADDR_PRCI_CTRL) &&
                    i_req.wdata[0];

  // Reset sequencer
  always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state      <= WAIT_LOCK;
      hold_cnt   <= '0;
      sys_nrst_q <= 1'b0;
      dbg_nrst_q <= 1'b0;
    end else if (!lock_sync) begin
      // Lost lock, system goes down, debug stays up
      state      <= WAIT_LOCK;
      hold_cnt   <= '0;
      sys_nrst_q <= 1'b0;
    end else if (soft_rst) begin
      state      <= HOLD;
      hold_cnt   <= '0;
      sys_nrst_q <= 1'b0;
    end else begin
      case (state)
        WAIT_LOCK: begin
          // Lock has already been seen for one cycle here
          state    <= HOLD;
          hold_cnt <= soc_pkg::hold_cnt_t'(1);
        end
        HOLD: begin
          if (hold_cnt == soc_pkg::hold_cnt_t'(soc_pkg::RST_HOLD_CYCLES - 1)) begin
            state      <= RUN;
            sys_nrst_q <= 1'b1;
            dbg_nrst_q <= 1'b1;
          end else begin
            hold_cnt <= hold_cnt + 1'b1;
          end
        end
        RUN: begin
          state <= RUN;
        end
        default: begin
          state <= WAIT_LOCK;
        end
      endcase
    end
  end

  assign o_sys_nrst = sys_nrst_q;
  assign o_dbg_nrst = dbg_nrst_q;

  // Register read mux, CTRL reads back as zero
  always_comb begin
    o_rsp.rdata = '0;
    if (i_req.addr == soc_pkg::ADDR_PRCI_STATUS) begin
      o_rsp.rdata[1:0] = {sys_nrst_q, lock_sync};
    end
  end

  // Debug domain only sees the power-up reset
  a_dbg_nrst_stable: assert property (
    @(posedge i_sys_clk) disable iff (!i_rst_n)
      !$fell(o_dbg_nrst))
    else $error("o_dbg_nrst fell while i_rst_n was high");

endmodule

//--- common/soc_pkg.sv
// Shared definitions for the SoC register subsystem
// Bus widths and structs, the register map and reset sequencing constants.
// Every RTL and testbench file refers to these by scoped names.

package soc_pkg;

  // Register bus widths
  typedef logic [7:0]  bus_addr_t;
  typedef logic [31:0] bus_data_t;

  // One bit per GPIO pin
  typedef logic [11:0] gpio_t;

  // Command sent by a master, then by the fabric to the slaves
  typedef struct packed {
    logic      we;
    bus_addr_t addr;
    bus_data_t wdata;
  } bus_req_t;

  // Read data returned by a slave or by the fabric
  typedef struct packed {
    bus_data_t rdata;
  } bus_rsp_t;

  // PRCI registers
  // STATUS bit0 is synchronized lock, bit1 is system running
  localparam bus_addr_t ADDR_PRCI_STATUS = 8'h00;
  // CTRL bit0 written as 1 requests a soft system reset, reads as 0
  localparam bus_addr_t ADDR_PRCI_CTRL   = 8'h04;

  // GPIO registers
  localparam bus_addr_t ADDR_GPIO_OUT = 8'h10;
  localparam bus_addr_t ADDR_GPIO_DIR = 8'h14;
  localparam bus_addr_t ADDR_GPIO_IN  = 8'h18;

  // Returned for reads of an unmapped address
  localparam bus_data_t BUS_ERR_DATA = 32'hDEAD_BEEF;

  // Cycles reset is held after lock or after a soft reset request
  localparam int RST_HOLD_CYCLES = 8;
  localparam int HOLD_CNT_W      = $clog2(RST_HOLD_CYCLES);

  typedef logic [HOLD_CNT_W-1:0] hold_cnt_t;

endpackage
